//--- hw/idu_settings.svh
`ifndef IDU_SETTINGS_SVH
`define IDU_SETTINGS_SVH

// Datapath widths
`define IDU_XLEN        32
`define IDU_ILEN        32
`define IDU_GPR_NUM     32
`define IDU_GPR_ID_W    5

// Buffering and flow control
`define IDU_FIFO_DEPTH  4
`define IDU_EXE_CREDITS 2
`define IDU_CREDIT_W    3

`endif

//--- hw/idu_pkg.sv
package idu_pkg;

    // RV32I major opcodes handled by the decoder
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [4:0] {
        ALU_NONE,
        ALU_ADD,  ALU_SUB,  ALU_SLL, ALU_SLT, ALU_SLTU,
        ALU_XOR,  ALU_SRL,  ALU_SRA, ALU_OR,  ALU_AND,
        ALU_JALR,
        ALU_BEQ,  ALU_BNE,  ALU_BLT, ALU_BGE, ALU_BLTU, ALU_BGEU
    } alu_op_e;

    typedef enum logic [1:0] {
        RS1_GPR,
        RS1_PC,
        RS1_ZERO
    } rs1_sel_e;

    typedef enum logic {
        RS2_GPR,
        RS2_IMM
    } rs2_sel_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_I, IMM_S, IMM_B, IMM_U, IMM_J
    } imm_fmt_e;

    typedef enum logic [1:0] {
        JMP_NONE, JMP_J, JMP_B
    } jmp_e;

    // Access size, S = sign extend, U = zero extend
    typedef enum logic [2:0] {
        BYT_NONE, BYT_1S, BYT_2S, BYT_4S, BYT_1U, BYT_2U, BYT_4U
    } ram_byt_e;

    typedef enum logic [1:0] {
        WR_NONE, WR_ALU, WR_MEM, WR_PC
    } wr_src_e;

endpackage

//--- hw/idu_inst_fifo.sv
`include "idu_settings.svh"

module idu_inst_fifo #(
    parameter int DEPTH = `IDU_FIFO_DEPTH
) (
    input  logic                 clk,
    input  logic                 i_rst_n,
    input  logic                 i_push,
    input  logic [`IDU_ILEN-1:0] i_push_inst,
    input  logic [`IDU_XLEN-1:0] i_push_pc,
    input  logic                 i_pop,
    output logic                 o_head_valid,
    output logic [`IDU_ILEN-1:0] o_head_inst,
    output logic [`IDU_XLEN-1:0] o_head_pc,
    output logic                 o_credit
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = PTR_W + 1;

    logic [`IDU_ILEN-1:0] inst_mem [DEPTH];
    logic [`IDU_XLEN-1:0] pc_mem   [DEPTH];
    logic [PTR_W-1:0]     wr_ptr;
    logic [PTR_W-1:0]     rd_ptr;
    logic [CNT_W-1:0]     count;

    always_ff @(posedge clk) begin
        if (i_push) begin
            inst_mem[wr_ptr] <= i_push_inst;
            pc_mem[wr_ptr]   <= i_push_pc;
        end
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            o_credit <= 1'b0;
        end else begin
            if (i_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (i_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count    <= count + CNT_W'(i_push) - CNT_W'(i_pop);
            // One credit back to fetch per freed slot
            o_credit <= i_pop;
        end
    end

    assign o_head_valid = (count != '0);
    assign o_head_inst  = inst_mem[rd_ptr];
    assign o_head_pc    = pc_mem[rd_ptr];

    // Fetch pushed without holding a credit
    a_no_overflow: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_push |-> (count < DEPTH));

    a_no_underflow: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_pop |-> (count != '0));

endmodule

//--- hw/idu_gpr_file.sv
`include "idu_settings.svh"

module idu_gpr_file (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic [`IDU_GPR_ID_W-1:0] i_rs1_id,
    input  logic [`IDU_GPR_ID_W-1:0] i_rs2_id,
    input  logic                     i_wb_en,
    input  logic [`IDU_GPR_ID_W-1:0] i_wb_rd_id,
    input  logic [`IDU_XLEN-1:0]     i_wb_data,
    output logic [`IDU_XLEN-1:0]     o_rs1_data,
    output logic [`IDU_XLEN-1:0]     o_rs2_data
);

    // x0 has no storage
    logic [`IDU_XLEN-1:0] regs [1:`IDU_GPR_NUM-1];

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < `IDU_GPR_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wb_en && (i_wb_rd_id != '0)) begin
            regs[i_wb_rd_id] <= i_wb_data;
        end
    end

    // Old value on a same-cycle write
    assign o_rs1_data = (i_rs1_id == '0) ? '0 : regs[i_rs1_id];
    assign o_rs2_data = (i_rs2_id == '0) ? '0 : regs[i_rs2_id];

    a_x0_zero: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_rs1_id == '0) |-> (o_rs1_data == '0));

endmodule

//--- hw/idu_imm_gen.sv
`include "idu_settings.svh"

module idu_imm_gen (
    input  logic [`IDU_ILEN-1:0] i_inst,
    output logic [`IDU_XLEN-1:0] o_imm,
    output idu_pkg::imm_fmt_e    o_imm_fmt
);
    import idu_pkg::*;

    always_comb begin
        case (i_inst[6:0])
            OP_LUI, OP_AUIPC:        o_imm_fmt = IMM_U;
            OP_JAL:                  o_imm_fmt = IMM_J;
            OP_JALR, OP_LOAD, OP_IMM: o_imm_fmt = IMM_I;
            OP_STORE:                o_imm_fmt = IMM_S;
            OP_BRANCH:               o_imm_fmt = IMM_B;
            default:                 o_imm_fmt = IMM_NONE;
        endcase
    end

    // Sign always comes from inst[31]
    always_comb begin
        case (o_imm_fmt)
            IMM_I:   o_imm = {{20{i_inst[31]}}, i_inst[31:20]};
            IMM_S:   o_imm = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
            IMM_B:   o_imm = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                              i_inst[11:8], 1'b0};
            IMM_U:   o_imm = {i_inst[31:12], 12'b0};
            IMM_J:   o_imm = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                              i_inst[30:21], 1'b0};
            default: o_imm = '0;
        endcase
    end

endmodule

//--- hw/idu_ctrl_decode.sv
`include "idu_settings.svh"

module idu_ctrl_decode (
    input  logic [`IDU_ILEN-1:0] i_inst,
    output idu_pkg::alu_op_e     o_alu_op,
    output idu_pkg::rs1_sel_e    o_rs1_sel,
    output idu_pkg::rs2_sel_e    o_rs2_sel,
    output idu_pkg::jmp_e        o_jmp_type,
    output logic                 o_ram_wr_en,
    output idu_pkg::ram_byt_e    o_ram_byt,
    output logic                 o_reg_wr_en,
    output idu_pkg::wr_src_e     o_reg_wr_src,
    output logic                 o_end_flag
);
    import idu_pkg::*;

    logic [2:0] funct3;
    logic       alt;

    assign funct3 = i_inst[14:12];
    // funct7 bit 5 picks SUB and SRA
    assign alt    = i_inst[30];

    always_comb begin
        o_alu_op     = ALU_NONE;
        o_rs1_sel    = RS1_ZERO;
        o_rs2_sel    = RS2_GPR;
        o_jmp_type   = JMP_NONE;
        o_ram_wr_en  = 1'b0;
        o_ram_byt    = BYT_NONE;
        o_reg_wr_en  = 1'b0;
        o_reg_wr_src = WR_NONE;
        o_end_flag   = 1'b0;
        case (i_inst[6:0])
            OP_LUI, OP_AUIPC: begin
                o_alu_op     = ALU_ADD;
                o_rs1_sel    = (i_inst[6:0] == OP_AUIPC) ? RS1_PC : RS1_ZERO;
                o_rs2_sel    = RS2_IMM;
                o_reg_wr_en  = 1'b1;
                o_reg_wr_src = WR_ALU;
            end
            OP_JAL, OP_JALR: begin
                o_alu_op     = (i_inst[6:0] == OP_JAL) ? ALU_ADD : ALU_JALR;
                o_rs1_sel    = (i_inst[6:0] == OP_JAL) ? RS1_PC : RS1_GPR;
                o_rs2_sel    = RS2_IMM;
                o_jmp_type   = JMP_J;
                o_reg_wr_en  = 1'b1;
                o_reg_wr_src = WR_PC;
            end
            OP_BRANCH: begin
                case (funct3)
                    3'b000:  o_alu_op = ALU_BEQ;
                    3'b001:  o_alu_op = ALU_BNE;
                    3'b100:  o_alu_op = ALU_BLT;
                    3'b101:  o_alu_op = ALU_BGE;
                    3'b110:  o_alu_op = ALU_BLTU;
                    3'b111:  o_alu_op = ALU_BGEU;
                    default: o_alu_op = ALU_NONE;
                endcase
                if (o_alu_op != ALU_NONE) begin
                    o_rs1_sel  = RS1_GPR;
                    o_jmp_type = JMP_B;
                end
            end
            OP_LOAD: begin
                case (funct3)
                    3'b000:  o_ram_byt = BYT_1S;
                    3'b001:  o_ram_byt = BYT_2S;
                    3'b010:  o_ram_byt = BYT_4S;
                    3'b100:  o_ram_byt = BYT_1U;
                    3'b101:  o_ram_byt = BYT_2U;
                    default: o_ram_byt = BYT_NONE;
                endcase
                if (o_ram_byt != BYT_NONE) begin
                    o_alu_op     = ALU_ADD;
                    o_rs1_sel    = RS1_GPR;
                    o_rs2_sel    = RS2_IMM;
                    o_reg_wr_en  = 1'b1;
                    o_reg_wr_src = WR_MEM;
                end
            end
            OP_STORE: begin
                case (funct3)
                    3'b000:  o_ram_byt = BYT_1U;
                    3'b001:  o_ram_byt = BYT_2U;
                    3'b010:  o_ram_byt = BYT_4U;
                    default: o_ram_byt = BYT_NONE;
                endcase
                if (o_ram_byt != BYT_NONE) begin
                    o_alu_op    = ALU_ADD;
                    o_rs1_sel   = RS1_GPR;
                    o_rs2_sel   = RS2_IMM;
                    o_ram_wr_en = 1'b1;
                end
            end
            OP_IMM, OP_REG: begin
                case (funct3)
                    3'b000: begin
                        o_alu_op = (i_inst[6:0] == OP_REG && alt) ? ALU_SUB : ALU_ADD;
                    end
                    3'b001:  o_alu_op = ALU_SLL;
                    3'b010:  o_alu_op = ALU_SLT;
                    3'b011:  o_alu_op = ALU_SLTU;
                    3'b100:  o_alu_op = ALU_XOR;
                    3'b101:  o_alu_op = alt ? ALU_SRA : ALU_SRL;
                    3'b110:  o_alu_op = ALU_OR;
                    default: o_alu_op = ALU_AND;
                endcase
                o_rs1_sel    = RS1_GPR;
                o_rs2_sel    = (i_inst[6:0] == OP_IMM) ? RS2_IMM : RS2_GPR;
                o_reg_wr_en  = 1'b1;
                o_reg_wr_src = WR_ALU;
            end
            // Only EBREAK is recognised here
            OP_SYSTEM: o_end_flag = (i_inst == 32'h0010_0073);
            default: ;
        endcase
    end

endmodule

//--- hw/idu_issue_stage.sv
`include "idu_settings.svh"

module idu_issue_stage (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_head_valid,
    input  logic [`IDU_XLEN-1:0]     i_pc,
    input  logic [`IDU_GPR_ID_W-1:0] i_rd_id,
    input  logic [`IDU_XLEN-1:0]     i_rs1_data,
    input  logic [`IDU_XLEN-1:0]     i_rs2_data,
    input  logic [`IDU_XLEN-1:0]     i_imm,
    input  idu_pkg::imm_fmt_e        i_imm_fmt,
    input  idu_pkg::alu_op_e         i_alu_op,
    input  idu_pkg::rs1_sel_e        i_rs1_sel,
    input  idu_pkg::rs2_sel_e        i_rs2_sel,
    input  idu_pkg::jmp_e            i_jmp_type,
    input  logic                     i_ram_wr_en,
    input  idu_pkg::ram_byt_e        i_ram_byt,
    input  logic                     i_reg_wr_en,
    input  idu_pkg::wr_src_e         i_reg_wr_src,
    input  logic                     i_end_flag,
    input  logic                     i_exe_credit,
    output logic                     o_pop,
    output logic                     o_idu_valid,
    output logic [`IDU_XLEN-1:0]     o_idu_pc,
    output logic [`IDU_XLEN-1:0]     o_idu_rs1_data,
    output logic [`IDU_XLEN-1:0]     o_idu_rs2_data,
    output logic [`IDU_XLEN-1:0]     o_idu_jmp_or_reg_data,
    output logic [`IDU_GPR_ID_W-1:0] o_idu_rd_id,
    output idu_pkg::alu_op_e         o_idu_alu_op,
    output idu_pkg::jmp_e            o_idu_jmp_type,
    output logic                     o_idu_ram_wr_en,
    output idu_pkg::ram_byt_e        o_idu_ram_byt,
    output logic                     o_idu_reg_wr_en,
    output idu_pkg::wr_src_e         o_idu_reg_wr_src,
    output logic                     o_idu_end_flag
);
    import idu_pkg::*;

    localparam int CW = `IDU_CREDIT_W;

    logic [CW-1:0]        credits;
    logic [`IDU_XLEN-1:0] rs1_op;
    logic [`IDU_XLEN-1:0] rs2_op;
    logic [`IDU_XLEN-1:0] jmp_or_reg;

    assign o_pop = i_head_valid && (credits != '0);

    always_comb begin
        case (i_rs1_sel)
            RS1_GPR: rs1_op = i_rs1_data;
            RS1_PC:  rs1_op = i_pc;
            default: rs1_op = '0;
        endcase
    end

    assign rs2_op     = (i_rs2_sel == RS2_IMM) ? i_imm : i_rs2_data;
    // Branch offset rides alongside the compare operands
    assign jmp_or_reg = (i_imm_fmt == IMM_B) ? i_imm : i_rs2_data;

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            credits         <= CW'(`IDU_EXE_CREDITS);
            o_idu_valid     <= 1'b0;
            o_idu_ram_wr_en <= 1'b0;
            o_idu_reg_wr_en <= 1'b0;
            o_idu_end_flag  <= 1'b0;
        end else begin
            credits         <= credits + CW'(i_exe_credit) - CW'(o_pop);
            o_idu_valid     <= o_pop;
            o_idu_ram_wr_en <= o_pop && i_ram_wr_en;
            o_idu_reg_wr_en <= o_pop && i_reg_wr_en;
            o_idu_end_flag  <= o_pop && i_end_flag;
        end
    end

    always_ff @(posedge clk) begin
        if (o_pop) begin
            o_idu_pc              <= i_pc;
            o_idu_rd_id           <= i_rd_id;
            o_idu_rs1_data        <= rs1_op;
            o_idu_rs2_data        <= rs2_op;
            o_idu_jmp_or_reg_data <= jmp_or_reg;
            o_idu_alu_op          <= i_alu_op;
            o_idu_jmp_type        <= i_jmp_type;
            o_idu_ram_byt         <= i_ram_byt;
            o_idu_reg_wr_src      <= i_reg_wr_src;
        end
    end

    a_credit_max: assert property (@(posedge clk) disable iff (!i_rst_n)
        credits <= `IDU_EXE_CREDITS);

    a_valid_has_credit: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_idu_valid |-> ($past(credits) != '0));

endmodule

//--- hw/idu_top.sv
`include "idu_settings.svh"

module idu_top (
    input  logic                     clk,
    input  logic                     i_rst_n,
    input  logic                     i_fetch_valid,
    input  logic [`IDU_ILEN-1:0]     i_fetch_inst,
    input  logic [`IDU_XLEN-1:0]     i_fetch_pc,
    output logic                     o_idu_credit,
    input  logic                     i_wb_en,
    input  logic [`IDU_GPR_ID_W-1:0] i_wb_rd_id,
    input  logic [`IDU_XLEN-1:0]     i_wb_data,
    input  logic                     i_exe_credit,
    output logic                     o_idu_valid,
    output logic [`IDU_XLEN-1:0]     o_idu_pc,
    output logic [`IDU_XLEN-1:0]     o_idu_rs1_data,
    output logic [`IDU_XLEN-1:0]     o_idu_rs2_data,
    output logic [`IDU_XLEN-1:0]     o_idu_jmp_or_reg_data,
    output logic [`IDU_GPR_ID_W-1:0] o_idu_rd_id,
    output idu_pkg::alu_op_e         o_idu_alu_op,
    output idu_pkg::jmp_e            o_idu_jmp_type,
    output logic                     o_idu_ram_wr_en,
    output idu_pkg::ram_byt_e        o_idu_ram_byt,
    output logic                     o_idu_reg_wr_en,
    output idu_pkg::wr_src_e         o_idu_reg_wr_src,
    output logic                     o_idu_end_flag
);
    import idu_pkg::*;

    logic                 head_valid;
    logic [`IDU_ILEN-1:0] head_inst;
    logic [`IDU_XLEN-1:0] head_pc;
    logic                 pop;
    logic [`IDU_XLEN-1:0] rs1_data;
    logic [`IDU_XLEN-1:0] rs2_data;
    logic [`IDU_XLEN-1:0] imm;
    imm_fmt_e             imm_fmt;
    alu_op_e              alu_op;
    rs1_sel_e             rs1_sel;
    rs2_sel_e             rs2_sel;
    jmp_e                 jmp_type;
    logic                 ram_wr_en;
    ram_byt_e             ram_byt;
    logic                 reg_wr_en;
    wr_src_e              reg_wr_src;
    logic                 end_flag;

    idu_inst_fifo #(
        .DEPTH(`IDU_FIFO_DEPTH)
    ) u_inst_fifo (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_push      (i_fetch_valid),
        .i_push_inst (i_fetch_inst),
        .i_push_pc   (i_fetch_pc),
        .i_pop       (pop),
        .o_head_valid(head_valid),
        .o_head_inst (head_inst),
        .o_head_pc   (head_pc),
        .o_credit    (o_idu_credit)
    );

    // Operands read straight from the FIFO head
    idu_gpr_file u_gpr_file (
        .clk       (clk),
        .i_rst_n   (i_rst_n),
        .i_rs1_id  (head_inst[19:15]),
        .i_rs2_id  (head_inst[24:20]),
        .i_wb_en   (i_wb_en),
        .i_wb_rd_id(i_wb_rd_id),
        .i_wb_data (i_wb_data),
        .o_rs1_data(rs1_data),
        .o_rs2_data(rs2_data)
    );

    idu_imm_gen u_imm_gen (
        .i_inst   (head_inst),
        .o_imm    (imm),
        .o_imm_fmt(imm_fmt)
    );

    idu_ctrl_decode u_ctrl_decode (
        .i_inst      (head_inst),
        .o_alu_op    (alu_op),
        .o_rs1_sel   (rs1_sel),
        .o_rs2_sel   (rs2_sel),
        .o_jmp_type  (jmp_type),
        .o_ram_wr_en (ram_wr_en),
        .o_ram_byt   (ram_byt),
        .o_reg_wr_en (reg_wr_en),
        .o_reg_wr_src(reg_wr_src),
        .o_end_flag  (end_flag)
    );

    idu_issue_stage u_issue_stage (
        .clk                  (clk),
        .i_rst_n              (i_rst_n),
        .i_head_valid         (head_valid),
        .i_pc                 (head_pc),
        .i_rd_id              (head_inst[11:7]),
        .i_rs1_data           (rs1_data),
        .i_rs2_data           (rs2_data),
        .i_imm                (imm),
        .i_imm_fmt            (imm_fmt),
        .i_alu_op             (alu_op),
        .i_rs1_sel            (rs1_sel),
        .i_rs2_sel            (rs2_sel),
        .i_jmp_type           (jmp_type),
        .i_ram_wr_en          (ram_wr_en),
        .i_ram_byt            (ram_byt),
        .i_reg_wr_en          (reg_wr_en),
        .i_reg_wr_src         (reg_wr_src),
        .i_end_flag           (end_flag),
        .i_exe_credit         (i_exe_credit),
        .o_pop                (pop),
        .o_idu_valid          (o_idu_valid),
        .o_idu_pc             (o_idu_pc),
        .o_idu_rs1_data       (o_idu_rs1_data),
        .o_idu_rs2_data       (o_idu_rs2_data),
        .o_idu_jmp_or_reg_data(o_idu_jmp_or_reg_data),
        .o_idu_rd_id          (o_idu_rd_id),
        .o_idu_alu_op         (o_idu_alu_op),
        .o_idu_jmp_type       (o_idu_jmp_type),
        .o_idu_ram_wr_en      (o_idu_ram_wr_en),
        .o_idu_ram_byt        (o_idu_ram_byt),
        .o_idu_reg_wr_en      (o_idu_reg_wr_en),
        .o_idu_reg_wr_src     (o_idu_reg_wr_src),
        .o_idu_end_flag       (o_idu_end_flag)
    );

endmodule

//--- testbench/tb_idu.sv
`include "idu_settings.svh"

module tb_idu;
    timeunit 1ns;
    timeprecision 1ps;
    import idu_pkg::*;

    localparam int N_INST = 200;
    localparam int LIMIT  = 20 * N_INST + 200;
    localparam logic [31:0] EBREAK = 32'h0010_0073;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] jr;
        logic [4:0]  rd;
        alu_op_e     alu;
        jmp_e        jmp;
        logic        ram_wr;
        ram_byt_e    byt;
        logic        reg_wr;
        wr_src_e     src;
        logic        ebrk;
        logic        chk;
    } bundle_t;

    logic        clk;
    logic        i_rst_n;
    logic        i_fetch_valid;
    logic [31:0] i_fetch_inst;
    logic [31:0] i_fetch_pc;
    logic        i_wb_en;
    logic [4:0]  i_wb_rd_id;
    logic [31:0] i_wb_data;
    logic        i_exe_credit;
    logic        o_idu_credit;
    logic        o_idu_valid;
    logic [31:0] o_idu_pc;
    logic [31:0] o_idu_rs1_data;
    logic [31:0] o_idu_rs2_data;
    logic [31:0] o_idu_jmp_or_reg_data;
    logic [4:0]  o_idu_rd_id;
    alu_op_e     o_idu_alu_op;
    jmp_e        o_idu_jmp_type;
    logic        o_idu_ram_wr_en;
    ram_byt_e    o_idu_ram_byt;
    logic        o_idu_reg_wr_en;
    wr_src_e     o_idu_reg_wr_src;
    logic        o_idu_end_flag;

    logic [31:0] gpr_model [32] = '{default: '0};
    bundle_t     exp_q [N_INST];
    int          chk_idx;
    int          credits_back;
    int          exe_held = 0;
    int          cycles = 0;
    logic        rst_d = 1'b0;

    idu_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic abort_run(string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Run aborted");
    endtask

    task automatic report_mismatch(string name, logic [31:0] got, logic [31:0] want);
        $display("FAILED at %0t ns: %s = %h, expected %h", $time, name, got, want);
        abort_run("Bundle field mismatch");
    endtask

    function automatic alu_op_e alu_for(logic [2:0] f3, logic alt);
        case (f3)
            3'd0:    return alt ? ALU_SUB : ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return alt ? ALU_SRA : ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    // Expected execute bundle from the RV32I encoding rules
    function automatic bundle_t expect_bundle(logic [31:0] inst, logic [31:0] pc);
        bundle_t     b;
        logic [2:0]  f3;
        logic [31:0] xs1;
        logic [31:0] xs2;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [12:0] b13;
        logic [20:0] j21;
        b     = '0;
        f3    = inst[14:12];
        xs1   = gpr_model[inst[19:15]];
        xs2   = gpr_model[inst[24:20]];
        imm_i = $signed(inst) >>> 20;
        imm_s = (imm_i & ~32'h1f) | inst[11:7];
        b13   = {inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        j21   = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
        b.pc  = pc;
        b.rd  = inst[11:7];
        b.jr  = xs2;
        b.chk = 1'b1;
        case (inst[6:0])
            OP_LUI, OP_AUIPC: begin
                b.alu = ALU_ADD;
                b.rs1 = (inst[6:0] == OP_AUIPC) ? pc : 32'h0;
                b.rs2 = inst & 32'hffff_f000;
                b.reg_wr = 1'b1;
                b.src = WR_ALU;
            end
            OP_JAL: begin
                b.alu = ALU_ADD;
                b.rs1 = pc;
                b.rs2 = 32'($signed(j21));
                b.jmp = JMP_J;
                b.reg_wr = 1'b1;
                b.src = WR_PC;
            end
            OP_JALR: begin
                b.alu = ALU_JALR;
                b.rs1 = xs1;
                b.rs2 = imm_i;
                b.jmp = JMP_J;
                b.reg_wr = 1'b1;
                b.src = WR_PC;
            end
            OP_BRANCH: begin
                case (f3)
                    3'd0:    b.alu = ALU_BEQ;
                    3'd1:    b.alu = ALU_BNE;
                    3'd4:    b.alu = ALU_BLT;
                    3'd5:    b.alu = ALU_BGE;
                    3'd6:    b.alu = ALU_BLTU;
                    default: b.alu = ALU_BGEU;
                endcase
                b.rs1 = xs1;
                b.rs2 = xs2;
                b.jr  = 32'($signed(b13));
                b.jmp = JMP_B;
            end
            OP_LOAD: begin
                case (f3)
                    3'd0:    b.byt = BYT_1S;
                    3'd1:    b.byt = BYT_2S;
                    3'd2:    b.byt = BYT_4S;
                    3'd4:    b.byt = BYT_1U;
                    default: b.byt = BYT_2U;
                endcase
                b.alu = ALU_ADD;
                b.rs1 = xs1;
                b.rs2 = imm_i;
                b.reg_wr = 1'b1;
                b.src = WR_MEM;
            end
            OP_STORE: begin
                b.byt = (f3 == 3'd0) ? BYT_1U : (f3 == 3'd1) ? BYT_2U : BYT_4U;
                b.alu = ALU_ADD;
                b.rs1 = xs1;
                b.rs2 = imm_s;
                b.ram_wr = 1'b1;
            end
            OP_IMM, OP_REG: begin
                b.alu = alu_for(f3, inst[30] && (inst[6:0] == OP_REG || f3 == 3'd5));
                b.rs1 = xs1;
                b.rs2 = (inst[6:0] == OP_IMM) ? imm_i : xs2;
                b.reg_wr = 1'b1;
                b.src = WR_ALU;
            end
            default: begin
                b.ebrk = (inst == EBREAK);
                b.chk  = 1'b0;
            end
        endcase
        return b;
    endfunction

    // Random legal instruction with x0 favoured as a source
    function automatic logic [31:0] make_inst();
        logic [31:0] r;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        r   = $urandom;
        rd  = r[11:7];
        rs1 = ($urandom_range(3) == 0) ? 5'd0 : r[19:15];
        rs2 = ($urandom_range(3) == 0) ? 5'd0 : r[24:20];
        f3  = 3'($urandom_range(7));
        f7  = ((f3 == 3'd0 || f3 == 3'd5) && $urandom_range(1) == 1) ? 7'h20 : 7'h00;
        case ($urandom_range(9))
            0: return {r[31:12], rd, OP_LUI};
            1: return {r[31:12], rd, OP_AUIPC};
            2: return {r[31:12], rd, OP_JAL};
            3: return {r[31:20], rs1, 3'b000, rd, OP_JALR};
            4: return {r[31:25], rs2, rs1, (f3 == 3'd2 || f3 == 3'd3) ? 3'd0 : f3, rd, OP_BRANCH};
            5: return {r[31:20], rs1, (f3 == 3'd3 || f3 > 3'd5) ? 3'd2 : f3, rd, OP_LOAD};
            6: return {r[31:25], rs2, rs1, 3'($urandom_range(2)), rd, OP_STORE};
            7: begin
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    return {(f3 == 3'd5) ? f7 : 7'h00, r[24:20], rs1, f3, rd, OP_IMM};
                end
                return {r[31:20], rs1, f3, rd, OP_IMM};
            end
            8: return {f7, rs2, rs1, f3, rd, OP_REG};
            default: return EBREAK;
        endcase
    endfunction

    task automatic preload_gprs();
        logic [31:0] data;
        for (int r = 0; r < 32; r++) begin
            data = $urandom | 32'h1;
            @(posedge clk);
            i_wb_en    <= 1'b1;
            i_wb_rd_id <= 5'(r);
            i_wb_data  <= data;
            if (r != 0) begin
                gpr_model[r] = data;
            end
        end
        @(posedge clk);
        i_wb_en <= 1'b0;
    endtask

    // Fetch side sends only while holding a credit
    task automatic send_program();
        int          sent;
        int          credits;
        logic [31:0] inst;
        sent    = 0;
        credits = `IDU_FIFO_DEPTH;
        while (sent < N_INST) begin
            @(posedge clk);
            if (o_idu_credit) begin
                credits++;
            end
            if (credits > 0 && $urandom_range(3) != 0) begin
                inst = make_inst();
                exp_q[sent] = expect_bundle(inst, 32'h1000 + 32'(sent * 4));
                i_fetch_valid <= 1'b1;
                i_fetch_inst  <= inst;
                i_fetch_pc    <= 32'h1000 + 32'(sent * 4);
                credits--;
                sent++;
            end else begin
                i_fetch_valid <= 1'b0;
            end
        end
        @(posedge clk);
        i_fetch_valid <= 1'b0;
    endtask

    // Execute side with random credit returns
    always @(posedge clk) begin
        rst_d <= i_rst_n;
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            abort_run("Timeout: not all instructions were issued in time");
        end else if (i_rst_n) begin
            exe_held = exe_held + int'(o_idu_valid) - int'(i_exe_credit);
            i_exe_credit <= (exe_held > 0) && ($urandom_range(2) == 0);
        end
    end

    always @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            chk_idx      <= 0;
            credits_back <= 0;
        end else begin
            if (o_idu_valid) begin
                chk_idx <= chk_idx + 1;
            end
            if (o_idu_credit) begin
                credits_back <= credits_back + 1;
            end
        end
    end

    a_reset_quiet: assert property (@(posedge clk) (!i_rst_n || !rst_d) |->
        !(o_idu_valid || o_idu_credit || o_idu_ram_wr_en || o_idu_reg_wr_en || o_idu_end_flag))
        else abort_run("Outputs active during or right after reset");
    a_exe_limit: assert property (@(posedge clk) disable iff (!i_rst_n)
        exe_held <= `IDU_EXE_CREDITS)
        else abort_run("More bundles outstanding than execute credits");
    a_no_extra: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_idu_valid |-> chk_idx < N_INST)
        else abort_run("Bundle issued with no instruction sent");
    a_credit_pair: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_idu_credit == o_idu_valid)
        else report_mismatch("o_idu_credit", $sampled(o_idu_credit), $sampled(o_idu_valid));

    a_pc: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_idu_valid |-> o_idu_pc == exp_q[chk_idx].pc)
        else report_mismatch("o_idu_pc", $sampled(o_idu_pc), $sampled(exp_q[chk_idx].pc));
    a_rs1: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_idu_valid && exp_q[chk_idx].chk |-> o_idu_rs1_data == exp_q[chk_idx].rs1)
        else report_mismatch("o_idu_rs1_data", $sampled(o_idu_rs1_data),
            $sampled(exp_q[chk_idx].rs1));
    a_rs2: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_idu_valid && exp_q[chk_idx].chk |-> o_idu_rs2_data == exp_q[chk_idx].rs2)
        else report_mismatch("o_idu_rs2_data", $sampled(o_idu_rs2_data),
            $sampled(exp_q[chk_idx].rs2));
    a_jr: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_idu_valid && exp_q[chk_idx].chk |-> o_idu_jmp_or_reg_data == exp_q[chk_idx].jr)
        else report_mismatch("o_idu_jmp_or_reg_data", $sampled(o_idu_jmp_or_reg_data),
            $sampled(exp_q[chk_idx].jr));
    a_rd: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_idu_valid |-> o_idu_rd_id == exp_q[chk_idx].rd)
        else report_mismatch("o_idu_rd_id", $sampled(o_idu_rd_id), $sampled(exp_q[chk_idx].rd));
    a_alu: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_idu_valid |-> o_idu_alu_op == exp_q[chk_idx].alu)
        else report_mismatch("o_idu_alu_op", $sampled(o_idu_alu_op),
            $sampled(exp_q[chk_idx].alu));
    a_jmp: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_idu_valid |-> o_idu_jmp_type == exp_q[chk_idx].jmp)
        else report_mismatch("o_idu_jmp_type", $sampled(o_idu_jmp_type),
            $sampled(exp_q[chk_idx].jmp));
    a_ram_wr: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_idu_valid |-> o_idu_ram_wr_en == exp_q[chk_idx].ram_wr)
        else report_mismatch("o_idu_ram_wr_en", $sampled(o_idu_ram_wr_en),
            $sampled(exp_q[chk_idx].ram_wr));
    a_byt: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_idu_valid |-> o_idu_ram_byt == exp_q[chk_idx].byt)
        else report_mismatch("o_idu_ram_byt", $sampled(o_idu_ram_byt),
            $sampled(exp_q[chk_idx].byt));
    a_reg_wr: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_idu_valid |-> o_idu_reg_wr_en == exp_q[chk_idx].reg_wr)
        else report_mismatch("o_idu_reg_wr_en", $sampled(o_idu_reg_wr_en),
            $sampled(exp_q[chk_idx].reg_wr));
    a_src: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_idu_valid |-> o_idu_reg_wr_src == exp_q[chk_idx].src)
        else report_mismatch("o_idu_reg_wr_src", $sampled(o_idu_reg_wr_src),
            $sampled(exp_q[chk_idx].src));
    a_end: assert property (@(posedge clk) disable iff (!i_rst_n)
        o_idu_valid |-> o_idu_end_flag == exp_q[chk_idx].ebrk)
        else report_mismatch("o_idu_end_flag", $sampled(o_idu_end_flag),
            $sampled(exp_q[chk_idx].ebrk));

    initial begin
        void'($urandom(64397));
        i_rst_n       = 1'b1;
        i_fetch_valid = 1'b0;
        i_fetch_inst  = '0;
        i_fetch_pc    = '0;
        i_wb_en       = 1'b0;
        i_wb_rd_id    = '0;
        i_wb_data     = '0;
        i_exe_credit  = 1'b0;
        i_rst_n      <= 1'b0;
        repeat (5) @(posedge clk);
        i_rst_n <= 1'b1;
        preload_gprs();
        send_program();
        while (chk_idx < N_INST) begin
            @(posedge clk);
        end
        repeat (10) @(posedge clk);
        if (credits_back == N_INST) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            abort_run("FIFO credit returns do not match issued instructions");
        end
    end

endmodule

//--- list.f
+incdir+hw
hw/idu_pkg.sv
hw/idu_inst_fifo.sv
hw/idu_gpr_file.sv
hw/idu_imm_gen.sv
hw/idu_ctrl_decode.sv
hw/idu_issue_stage.sv
hw/idu_top.sv
testbench/tb_idu.sv

//--- Bender.yml
package:
  name: idu

sources:
  - include_dirs:
      - hw
    files:
      - hw/idu_pkg.sv
      - hw/idu_inst_fifo.sv
      - hw/idu_gpr_file.sv
      - hw/idu_imm_gen.sv
      - hw/idu_ctrl_decode.sv
      - hw/idu_issue_stage.sv
      - hw/idu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/tb_idu.sv
